// ==== project.f ====
verilog/vb_bus_pkg.sv
verilog/vb_ctrl_pkg.sv
verilog/vb_req_arb.sv
verilog/vb_entry_ctrl.sv
verilog/vb_line_store.sv
verilog/lsu_vb_top.sv
tests/lsu_vb_asserts.sv
tests/tb_lsu_vb.sv

// ==== tests/lsu_vb_asserts.sv ====
// victim buffer bound assertions
module lsu_vb_asserts (
  input logic              vb_clk,
  input logic              cpurst_b,
  input logic              awvalid,
  input logic              lfb_rvalid,
  input logic              wvalid,
  input logic              wready,
  input vb_bus_pkg::beat_t wdata,
  input logic              idle,
  input logic              rdl_grant,
  input logic              icc_grant
);

  // ============================================================
  // drain exclusion and bus hold
  // ============================================================
  // only one drain path reads the line at a time
  a_one_drain: assert property (@(posedge vb_clk) disable iff (!cpurst_b)
    !(awvalid && lfb_rvalid))
    else $error("awvalid and lfb_rvalid high together");

  // stalled write beat keeps valid and data
  a_w_hold: assert property (@(posedge vb_clk) disable iff (!cpurst_b)
    (wvalid && !wready) |=> (wvalid && $stable(wdata)))
    else $error("wvalid or wdata changed while wready low");

  // grants only while the entry is free
  a_grant_idle: assert property (@(posedge vb_clk) disable iff (!cpurst_b)
    (rdl_grant || icc_grant) |-> idle)
    else $error("grant high while not idle");

endmodule

bind lsu_vb_top lsu_vb_asserts u_asserts (.*);

// ==== tests/tb_lsu_vb.sv ====
// victim buffer testbench
module tb_lsu_vb;

  import vb_bus_pkg::*;
  import vb_ctrl_pkg::*;

  localparam logic [31:0] rand_seed  = 32'h6ec8_5472;
  localparam int          wait_limit = 200;
  // selectors for output_high
  localparam int sel_awvalid = 0;
  localparam int sel_rvalid  = 1;
  localparam int sel_idle    = 2;

  typedef logic [beats_per_line-1:0][beat_w-1:0] line_t;

  logic vb_clk;
  logic cpurst_b;
  logic rdl_req, icc_req, icc_fill_vld;
  vb_req_t rdl_req_info;
  vb_fill_t rdl_fill;
  line_addr_t icc_addr;
  beat_t icc_data;
  logic awready, wready, lfb_arvalid, lfb_rready, biu_no_op;
  ld_id_t lfb_arid;
  beat_idx_t lfb_araddr_5_4;
  pa_t dc_pa;
  logic rdl_grant, ld_alias_hit, icc_grant, icc_empty;
  logic awvalid, wvalid, wlast, lfb_arready, lfb_rvalid, lfb_rlast, lfb_dirty;
  pa_t awaddr;
  beat_t wdata, lfb_rdata;
  bus_id_t lfb_rid;
  logic dc_hit_idx, dc_pop_en, idle;

  // expected line and drain positions, shared with the checker
  line_t ref_line;
  beat_idx_t ref_start;
  int wb_pos, rd_pos;
  int errors, test_base, tests_run, beats_seen;
  logic bp_on;
  int seed_ret;

  lsu_vb_top DUT (.*);

  initial begin
    vb_clk = 1'b1;
    forever #4 vb_clk = ~vb_clk;
  end

  // ============================================================
  // reference and reporting
  // ============================================================
  // beat seen at position pos of a drain starting at start
  function automatic beat_t expect_beat(input line_t line, input beat_idx_t start, input int pos);
    int idx;
    idx = (int'(start) + pos) % beats_per_line;
    return line[idx];
  endfunction

  function automatic line_t random_line();
    line_t l;
    for (int k = 0; k < beats_per_line; k++) begin
      l[k] = {$urandom, $urandom, $urandom, $urandom};
    end
    return l;
  endfunction

  function automatic logic output_high(input int sel);
    case (sel)
      sel_awvalid: return awvalid;
      sel_rvalid:  return lfb_rvalid;
      default:     return idle;
    endcase
  endfunction

  task automatic log_mismatch(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s did not happen within %0d cycles", why, wait_limit);
    $display("ERRORS FOUND");
    $finish;
  endtask

  // each wait has its own cycle limit
  task automatic wait_high(input int sel, input string what);
    int n;
    n = 0;
    while (output_high(sel) !== 1'b1 && n < wait_limit) begin
      @(negedge vb_clk);
      n++;
    end
    if (output_high(sel) !== 1'b1) abort_run(what);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %-14s %s", name, (errors == test_base) ? "passed" : "failed");
    test_base = errors;
  endtask

  // ============================================================
  // beat checker
  // ============================================================
  // sampled on the rising edge, before the DUT registers update
  always @(posedge vb_clk) begin : compare_beats
    beat_t exp;
    if (cpurst_b === 1'b1) begin
      if (wvalid && wready) begin
        exp = expect_beat(ref_line, '0, wb_pos);
        if (wdata !== exp)
          log_mismatch($sformatf("wdata beat %0d got %h expected %h", wb_pos, wdata, exp));
        if (wlast !== (wb_pos == 3)) log_mismatch($sformatf("wlast wrong at beat %0d", wb_pos));
        if (dc_pop_en !== (wb_pos == 3))
          log_mismatch($sformatf("dc_pop_en wrong at wb beat %0d", wb_pos));
        wb_pos++;
        beats_seen++;
      end else if (lfb_rvalid && lfb_rready) begin
        exp = expect_beat(ref_line, ref_start, rd_pos);
        if (lfb_rdata !== exp)
          log_mismatch($sformatf("rdata beat %0d got %h expected %h", rd_pos, lfb_rdata, exp));
        if (lfb_rlast !== (rd_pos == 3)) log_mismatch($sformatf("rlast wrong at beat %0d", rd_pos));
        if (dc_pop_en !== (rd_pos == 3))
          log_mismatch($sformatf("dc_pop_en wrong at alias beat %0d", rd_pos));
        rd_pos++;
        beats_seen++;
      end else if (dc_pop_en) begin
        log_mismatch("dc_pop_en without a final beat");
      end
    end
  end

  // readies, random low cycles under back-pressure
  always @(negedge vb_clk) begin
    awready    = bp_on ? (($urandom % 3) != 0) : 1'b1;
    wready     = bp_on ? (($urandom % 3) != 0) : 1'b1;
    lfb_rready = bp_on ? (($urandom % 3) != 0) : 1'b1;
  end

  // ============================================================
  // stimulus tasks
  // ============================================================
  // four fill beats, with random gaps under back-pressure
  task automatic fill_line(input logic use_rdl, input logic use_icc, input line_t line_r,
                           input line_t line_i, input logic dirty);
    for (int k = 0; k < beats_per_line; k++) begin
      if (bp_on) repeat ($urandom % 3) @(negedge vb_clk);
      rdl_fill.vld   = use_rdl;
      rdl_fill.dirty = (k == 0) ? dirty : 1'b0;
      rdl_fill.data  = line_r[k];
      icc_fill_vld   = use_icc;
      icc_data       = line_i[k];
      @(negedge vb_clk);
      rdl_fill.vld = 1'b0;
      icc_fill_vld = 1'b0;
    end
  endtask

  // request from rdl, icc or both, grants checked in the same cycle
  task automatic request_entry(input logic use_rdl, input logic use_icc, input vb_req_t info,
                               input line_addr_t addr_i);
    rdl_req      = use_rdl;
    rdl_req_info = info;
    icc_req      = use_icc;
    icc_addr     = addr_i;
    #1;
    if (idle !== 1'b1 || rdl_grant !== 1'b1) log_mismatch("rdl_grant low while idle");
    if (icc_grant !== !use_rdl) log_mismatch($sformatf("icc_grant %b with rdl_req %b",
                                                       icc_grant, use_rdl));
    @(negedge vb_clk);
    rdl_req = 1'b0;
    icc_req = 1'b0;
  endtask

  task automatic run_writeback(input logic use_rdl, input logic use_icc);
    line_t line_r, line_i;
    line_addr_t addr_i, addr_exp;
    vb_req_t info;
    line_r     = random_line();
    line_i     = random_line();
    addr_i     = line_addr_t'({$urandom, $urandom});
    info       = '0;
    info.addr  = line_addr_t'({$urandom, $urandom});
    info.ld    = $urandom % 2;
    info.ld_id = ld_id_t'($urandom);
    // rdl data wins whenever rdl fills
    ref_line   = use_rdl ? line_r : line_i;
    addr_exp   = use_rdl ? info.addr : addr_i;
    ref_start  = '0;
    wb_pos     = 0;
    rd_pos     = 0;
    request_entry(use_rdl, use_icc, info, addr_i);
    fill_line(use_rdl, use_icc, line_r, line_i, 1'b1);
    wait_high(sel_awvalid, "awvalid after the fill");
    if (awaddr !== {addr_exp, 6'b0})
      log_mismatch($sformatf("awaddr got %h expected %h", awaddr, {addr_exp, 6'b0}));
    if (icc_empty !== 1'b0) log_mismatch("icc_empty high while busy");
    if (ld_alias_hit !== 1'b0) log_mismatch("ld_alias_hit high for a write-back victim");
    // index hit while busy, match then miss
    dc_pa = pa_t'({$urandom, $urandom});
    dc_pa[13:6] = addr_exp[7:0];
    #1;
    if (dc_hit_idx !== 1'b1) log_mismatch("dc_hit_idx low on a matching index");
    @(negedge vb_clk);
    dc_pa[13:6] = ~addr_exp[7:0];
    #1;
    if (dc_hit_idx !== 1'b0) log_mismatch("dc_hit_idx high on a different index");
    wait_high(sel_idle, "return to idle after write-back");
    if (wb_pos !== 4) log_mismatch($sformatf("%0d write beats accepted, expected 4", wb_pos));
    if (icc_empty !== biu_no_op) log_mismatch("icc_empty wrong while idle");
    dc_pa[13:6] = addr_exp[7:0];
    #1;
    if (dc_hit_idx !== 1'b0) log_mismatch("dc_hit_idx high while idle");
  endtask

  task automatic run_alias(input logic pf);
    line_t line_r;
    vb_req_t info;
    logic dirty;
    beat_idx_t start;
    bus_id_t rid_exp;
    line_r        = random_line();
    info          = '0;
    info.addr     = line_addr_t'({$urandom, $urandom});
    info.is_alias = 1'b1;
    info.ld       = 1'b1;
    info.pf       = pf;
    info.ld_id    = ld_id_t'($urandom);
    dirty         = $urandom % 2;
    start         = beat_idx_t'($urandom);
    ref_line      = line_r;
    ref_start     = start;
    wb_pos        = 0;
    rd_pos        = 0;
    request_entry(1'b1, 1'b0, info, '0);
    fill_line(1'b1, 1'b0, line_r, '0, dirty);
    // entry now waits in alias_req
    if (ld_alias_hit !== 1'b1) log_mismatch("ld_alias_hit low for an aliased load");
    lfb_arvalid    = 1'b1;
    lfb_arid       = info.ld_id + 1'b1;
    lfb_araddr_5_4 = start;
    repeat (2) begin
      #1;
      if (lfb_arready !== 1'b0) log_mismatch("arready on a mismatched arid");
      @(negedge vb_clk);
    end
    lfb_arid = info.ld_id;
    #1;
    if (lfb_arready !== 1'b1) log_mismatch("no arready on the matching arid");
    wait_high(sel_rvalid, "lfb_rvalid after arready");
    lfb_arvalid = 1'b0;
    rid_exp = pf ? {1'b1, info.ld_id} : vb_bus_id;
    if (lfb_rid !== rid_exp) log_mismatch($sformatf("rid got %h expected %h", lfb_rid, rid_exp));
    if (lfb_dirty !== dirty) log_mismatch($sformatf("lfb_dirty got %b expected %b",
                                                    lfb_dirty, dirty));
    wait_high(sel_idle, "return to idle after alias drain");
    if (rd_pos !== 4) log_mismatch($sformatf("%0d alias beats accepted, expected 4", rd_pos));
  endtask

  // ============================================================
  // test sequence
  // ============================================================
  initial begin
    seed_ret       = $urandom(rand_seed);
    cpurst_b       = 1'b0;
    rdl_req        = 1'b0;
    rdl_req_info   = '0;
    rdl_fill       = '0;
    icc_req        = 1'b0;
    icc_addr       = '0;
    icc_fill_vld   = 1'b0;
    icc_data       = '0;
    awready        = 1'b1;
    wready         = 1'b1;
    lfb_arvalid    = 1'b0;
    lfb_arid       = '0;
    lfb_araddr_5_4 = '0;
    lfb_rready     = 1'b1;
    biu_no_op      = 1'b1;
    dc_pa          = '0;
    bp_on          = 1'b0;
    errors         = 0;
    test_base      = 0;
    tests_run      = 0;
    beats_seen     = 0;
    wb_pos         = 0;
    rd_pos         = 0;
    ref_line       = '0;
    ref_start      = '0;
    repeat (2) @(negedge vb_clk);
    cpurst_b = 1'b1;
    #1;
    if (!idle || !rdl_grant || !icc_grant || awvalid || wvalid || lfb_rvalid || dc_pop_en)
      log_mismatch("outputs wrong after reset");
    @(negedge vb_clk);

    run_writeback(1'b0, 1'b1);
    biu_no_op = 1'b0;
    #1;
    if (icc_empty !== 1'b0) log_mismatch("icc_empty high while biu busy");
    @(negedge vb_clk);
    biu_no_op = 1'b1;
    end_test("icc clean");

    run_writeback(1'b1, 1'b1);
    end_test("priority");

    run_alias(1'b0);
    run_alias(1'b1);
    end_test("alias drain");

    bp_on = 1'b1;
    run_writeback(1'b0, 1'b1);
    run_alias(1'b0);
    run_writeback(1'b1, 1'b0);
    bp_on = 1'b0;
    end_test("back-pressure");

    run_writeback(1'b1, 1'b0);
    end_test("index hit");

    $display("tests %0d, beats checked %0d, errors %0d", tests_run, beats_seen, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verilog/lsu_vb_top.sv ====
// load/store unit victim buffer
module lsu_vb_top (
  input  logic                   vb_clk,
  input  logic                   cpurst_b,
  // replacement unit
  input  logic                   rdl_req,
  input  vb_ctrl_pkg::vb_req_t   rdl_req_info,
  input  vb_ctrl_pkg::vb_fill_t  rdl_fill,
  output logic                   rdl_grant,
  output logic                   ld_alias_hit,
  // cache clean unit
  input  logic                   icc_req,
  input  vb_bus_pkg::line_addr_t icc_addr,
  input  logic                   icc_fill_vld,
  input  vb_bus_pkg::beat_t      icc_data,
  output logic                   icc_grant,
  output logic                   icc_empty,
  // bus write-back
  output logic                   awvalid,
  output vb_bus_pkg::pa_t        awaddr,
  input  logic                   awready,
  output logic                   wvalid,
  output vb_bus_pkg::beat_t      wdata,
  output logic                   wlast,
  input  logic                   wready,
  // line-fill buffer
  input  logic                   lfb_arvalid,
  input  vb_bus_pkg::ld_id_t     lfb_arid,
  input  vb_bus_pkg::beat_idx_t  lfb_araddr_5_4,
  output logic                   lfb_arready,
  output logic                   lfb_rvalid,
  output vb_bus_pkg::beat_t      lfb_rdata,
  output logic                   lfb_rlast,
  output vb_bus_pkg::bus_id_t    lfb_rid,
  input  logic                   lfb_rready,
  output logic                   lfb_dirty,
  // biu and dc
  input  logic                   biu_no_op,
  input  vb_bus_pkg::pa_t        dc_pa,
  output logic                   dc_hit_idx,
  output logic                   dc_pop_en,
  output logic                   idle
);

  import vb_bus_pkg::*;
  import vb_ctrl_pkg::*;

  logic      req_vld;
  vb_req_t   req;
  vb_fill_t  fill;
  logic      wr_en;
  beat_idx_t wr_idx;
  beat_idx_t wb_idx;
  beat_idx_t alias_idx;

  // ============================================================
  // entry arbitration
  // ============================================================
  vb_req_arb u_req_arb (
    .rdl_req      (rdl_req),
    .rdl_req_info (rdl_req_info),
    .rdl_fill     (rdl_fill),
    .icc_req      (icc_req),
    .icc_addr     (icc_addr),
    .icc_fill_vld (icc_fill_vld),
    .icc_data     (icc_data),
    .entry_idle   (idle),
    .req_vld      (req_vld),
    .req          (req),
    .fill         (fill),
    .rdl_grant    (rdl_grant),
    .icc_grant    (icc_grant)
  );

  // ============================================================
  // control
  // ============================================================
  vb_entry_ctrl u_entry_ctrl (
    .vb_clk         (vb_clk),
    .cpurst_b       (cpurst_b),
    .req_vld        (req_vld),
    .req            (req),
    .fill           (fill),
    .awready        (awready),
    .wready         (wready),
    .lfb_arvalid    (lfb_arvalid),
    .lfb_arid       (lfb_arid),
    .lfb_araddr_5_4 (lfb_araddr_5_4),
    .lfb_rready     (lfb_rready),
    .biu_no_op      (biu_no_op),
    .dc_pa          (dc_pa),
    .wr_en          (wr_en),
    .wr_idx         (wr_idx),
    .wb_idx         (wb_idx),
    .alias_idx      (alias_idx),
    .entry_idle     (idle),
    .awvalid        (awvalid),
    .awaddr         (awaddr),
    .wvalid         (wvalid),
    .wlast          (wlast),
    .lfb_arready    (lfb_arready),
    .lfb_rvalid     (lfb_rvalid),
    .lfb_rlast      (lfb_rlast),
    .lfb_rid        (lfb_rid),
    .lfb_dirty      (lfb_dirty),
    .ld_alias_hit   (ld_alias_hit),
    .dc_hit_idx     (dc_hit_idx),
    .dc_pop_en      (dc_pop_en),
    .icc_empty      (icc_empty)
  );

  // ============================================================
  // line data
  // ============================================================
  // bus and lfb each get their own read port
  vb_line_store u_line_store (
    .vb_clk     (vb_clk),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .wr_data    (fill.data),
    .wb_idx     (wb_idx),
    .alias_idx  (alias_idx),
    .wb_data    (wdata),
    .alias_data (lfb_rdata)
  );

endmodule

// ==== verilog/vb_bus_pkg.sv ====
// victim buffer port definitions
package vb_bus_pkg;

  // ============================================================
  // widths
  // ============================================================
  // line address, pa without the 6 offset bits
  localparam int line_addr_w    = 34;
  localparam int pa_w           = 40;
  // one beat is a quarter line
  localparam int beat_w         = 128;
  localparam int beats_per_line = 4;
  localparam int line_offset_w  = 6;
  // dc tag index, pa bits 13:6
  localparam int dc_idx_w       = 8;
  localparam int ld_id_w        = 3;
  localparam int bus_id_w       = 4;

  // ============================================================
  // vector types
  // ============================================================
  typedef logic [line_addr_w-1:0]              line_addr_t;
  typedef logic [pa_w-1:0]                     pa_t;
  typedef logic [beat_w-1:0]                   beat_t;
  typedef logic [$clog2(beats_per_line)-1:0]   beat_idx_t;
  typedef logic [ld_id_w-1:0]                  ld_id_t;
  typedef logic [bus_id_w-1:0]                 bus_id_t;
  typedef logic [dc_idx_w-1:0]                 dc_idx_t;

  // ============================================================
  // fixed bus codes
  // ============================================================
  // write-back id, also the reply id of a plain load
  localparam bus_id_t vb_bus_id = 4'b0100;

endpackage

// ==== verilog/vb_ctrl_pkg.sv ====
// victim buffer control types
package vb_ctrl_pkg;

  import vb_bus_pkg::*;

  // ============================================================
  // entry state machine
  // ============================================================
  // fill states keep the beat number in bits 1:0
  typedef enum logic [3:0] {
    st_idle      = 4'b0000,
    st_bus_req   = 4'b0001,
    st_bus_wfc   = 4'b0010,
    st_alias_req = 4'b0011,
    st_alias_wfc = 4'b0100,
    st_data_0    = 4'b1000,
    st_data_1    = 4'b1001,
    st_data_2    = 4'b1010,
    st_data_3    = 4'b1011
  } vb_state_e;

  // ============================================================
  // request and fill bundles
  // ============================================================
  // attributes captured when the entry is created
  typedef struct packed {
    line_addr_t addr;
    logic       is_alias;
    logic       ld;
    logic       pf;
    ld_id_t     ld_id;
  } vb_req_t;

  // one fill beat, dirty only meaningful with beat 0
  typedef struct packed {
    logic       vld;
    logic       dirty;
    beat_t      data;
  } vb_fill_t;

endpackage

// ==== verilog/vb_entry_ctrl.sv ====
// victim entry controller
module vb_entry_ctrl (
  input  logic                   vb_clk,
  input  logic                   cpurst_b,
  input  logic                   req_vld,
  input  vb_ctrl_pkg::vb_req_t   req,
  input  vb_ctrl_pkg::vb_fill_t  fill,
  input  logic                   awready,
  input  logic                   wready,
  input  logic                   lfb_arvalid,
  input  vb_bus_pkg::ld_id_t     lfb_arid,
  input  vb_bus_pkg::beat_idx_t  lfb_araddr_5_4,
  input  logic                   lfb_rready,
  input  logic                   biu_no_op,
  input  vb_bus_pkg::pa_t        dc_pa,
  output logic                   wr_en,
  output vb_bus_pkg::beat_idx_t  wr_idx,
  output vb_bus_pkg::beat_idx_t  wb_idx,
  output vb_bus_pkg::beat_idx_t  alias_idx,
  output logic                   entry_idle,
  output logic                   awvalid,
  output vb_bus_pkg::pa_t        awaddr,
  output logic                   wvalid,
  output logic                   wlast,
  output logic                   lfb_arready,
  output logic                   lfb_rvalid,
  output logic                   lfb_rlast,
  output vb_bus_pkg::bus_id_t    lfb_rid,
  output logic                   lfb_dirty,
  output logic                   ld_alias_hit,
  output logic                   dc_hit_idx,
  output logic                   dc_pop_en,
  output logic                   icc_empty
);

  import vb_bus_pkg::*;
  import vb_ctrl_pkg::*;

  vb_state_e state;
  vb_state_e state_nxt;
  vb_req_t   entry;
  logic      dirty;
  beat_idx_t beat_cnt;
  beat_idx_t alias_ptr;
  logic      cnt_last;
  logic      busy;
  logic      wb_beat_acc;
  logic      alias_beat_acc;

  // ============================================================
  // state machine
  // ============================================================
  always_ff @(posedge vb_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:      if (req_vld) state_nxt = st_data_0;
      st_data_0:    if (fill.vld) state_nxt = st_data_1;
      st_data_1:    if (fill.vld) state_nxt = st_data_2;
      st_data_2:    if (fill.vld) state_nxt = st_data_3;
      // last beat picks the drain path
      st_data_3: begin
        if (fill.vld) state_nxt = entry.is_alias ? st_alias_req : st_bus_req;
      end
      st_bus_req:   if (awready) state_nxt = st_bus_wfc;
      st_bus_wfc:   if (wb_beat_acc && cnt_last) state_nxt = st_idle;
      st_alias_req: if (lfb_arready) state_nxt = st_alias_wfc;
      st_alias_wfc: if (alias_beat_acc && cnt_last) state_nxt = st_idle;
      default:      state_nxt = st_idle;
    endcase
  end

  assign entry_idle = (state == st_idle);
  assign busy       = ~entry_idle;

  // ============================================================
  // entry attributes
  // ============================================================
  // taken in the same cycle as the grant
  always_ff @(posedge vb_clk) begin
    if (req_vld && entry_idle) begin
      entry <= req;
    end
  end

  // dirty travels with beat 0
  always_ff @(posedge vb_clk) begin
    if (wr_en && (wr_idx == '0)) begin
      dirty <= fill.dirty;
    end
  end

  // line store write, beat number from the fill state
  assign wr_en  = state[3] & fill.vld;
  assign wr_idx = state[1:0];

  // ============================================================
  // beat counter and critical beat pointer
  // ============================================================
  assign wb_beat_acc    = (state == st_bus_wfc) & wready;
  assign alias_beat_acc = (state == st_alias_wfc) & lfb_rready;

  // counts accepted beats of either drain, wraps back to 0
  always_ff @(posedge vb_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      beat_cnt <= '0;
    end else if (wb_beat_acc || alias_beat_acc) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign cnt_last = (beat_cnt == beat_idx_t'(beats_per_line - 1));

  // lfb asks for its critical beat first
  always_ff @(posedge vb_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      alias_ptr <= '0;
    end else if (lfb_arready) begin
      alias_ptr <= lfb_araddr_5_4;
    end else if (alias_beat_acc) begin
      alias_ptr <= alias_ptr + 1'b1;
    end
  end

  assign wb_idx    = beat_cnt;
  assign alias_idx = alias_ptr;

  // ============================================================
  // bus write-back
  // ============================================================
  assign awvalid = (state == st_bus_req);
  assign awaddr  = {entry.addr, {line_offset_w{1'b0}}};
  assign wvalid  = (state == st_bus_wfc);
  assign wlast   = cnt_last;

  // ============================================================
  // lfb alias drain
  // ============================================================
  // only the load that caused the alias may take the line
  assign lfb_arready  = (state == st_alias_req) & lfb_arvalid & (lfb_arid == entry.ld_id);
  assign lfb_rvalid   = (state == st_alias_wfc);
  assign lfb_rlast    = cnt_last;
  // plain loads reply on the shared id
  assign lfb_rid      = (entry.ld && !entry.pf) ? vb_bus_id : {1'b1, entry.ld_id};
  assign lfb_dirty    = dirty;
  assign ld_alias_hit = busy & entry.ld & entry.is_alias;

  // ============================================================
  // dc status
  // ============================================================
  assign dc_hit_idx = busy &
                      (dc_pa[dc_idx_w+line_offset_w-1:line_offset_w] ==
                       dc_idx_t'(entry.addr[dc_idx_w-1:0]));
  // final beat of whichever drain is running
  assign dc_pop_en  = (wb_beat_acc | alias_beat_acc) & cnt_last;
  assign icc_empty  = entry_idle & biu_no_op;

endmodule

// ==== verilog/vb_line_store.sv ====
// victim line storage
module vb_line_store (
  input  logic                  vb_clk,
  input  logic                  wr_en,
  input  vb_bus_pkg::beat_idx_t wr_idx,
  input  vb_bus_pkg::beat_t     wr_data,
  input  vb_bus_pkg::beat_idx_t wb_idx,
  input  vb_bus_pkg::beat_idx_t alias_idx,
  output vb_bus_pkg::beat_t     wb_data,
  output vb_bus_pkg::beat_t     alias_data
);

  import vb_bus_pkg::*;

  // one line, four beats
  beat_t beats [beats_per_line];

  // ============================================================
  // write port
  // ============================================================
  // one beat per fill strobe
  always_ff @(posedge vb_clk) begin
    if (wr_en) begin
      beats[wr_idx] <= wr_data;
    end
  end

  // ============================================================
  // read ports
  // ============================================================
  // bus drain walks beats in order
  assign wb_data    = beats[wb_idx];

  // alias drain starts at the critical beat
  assign alias_data = beats[alias_idx];

endmodule

// ==== verilog/vb_req_arb.sv ====
// rdl and icc request arbiter
module vb_req_arb (
  input  logic                   rdl_req,
  input  vb_ctrl_pkg::vb_req_t   rdl_req_info,
  input  vb_ctrl_pkg::vb_fill_t  rdl_fill,
  input  logic                   icc_req,
  input  vb_bus_pkg::line_addr_t icc_addr,
  input  logic                   icc_fill_vld,
  input  vb_bus_pkg::beat_t      icc_data,
  input  logic                   entry_idle,
  output logic                   req_vld,
  output vb_ctrl_pkg::vb_req_t   req,
  output vb_ctrl_pkg::vb_fill_t  fill,
  output logic                   rdl_grant,
  output logic                   icc_grant
);

  import vb_ctrl_pkg::*;

  // ============================================================
  // request select, rdl first
  // ============================================================
  assign req_vld = rdl_req | icc_req;

  // icc never aliases and is never a load
  assign req = rdl_req ? rdl_req_info :
               '{addr: icc_addr, is_alias: 1'b0, ld: 1'b0, pf: 1'b0, ld_id: '0};

  // ============================================================
  // fill beat select
  // ============================================================
  // chosen on its own strobe, not on the request winner
  // icc lines are always written back dirty
  assign fill = rdl_fill.vld ? rdl_fill :
                '{vld: icc_fill_vld, dirty: 1'b1, data: icc_data};

  // ============================================================
  // grants
  // ============================================================
  // grant in the cycle the request is seen while idle
  assign rdl_grant = entry_idle;
  // icc loses to any rdl request
  assign icc_grant = entry_idle & ~rdl_req;

endmodule
